//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module tb_pkt_client -o tb_pkt_client
	./obj_dir/tb_pkt_client | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hw/lpbk_fifo.sv
/* loopback beat FIFO, drops writes when full and latches an overflow flag */
`timescale 1ns/1ps
`include "pkt_client_params.svh"

module lpbk_fifo (
    input  logic                        i_clk_tx,
    input  logic                        tx_reset,
    input  logic                        i_wr,
    input  pkt_client_pkg::avst_beat_t  i_wr_beat,
    input  logic                        i_pop,
    input  logic                        i_ovf_clr,
    output logic                        o_valid,
    output pkt_client_pkg::avst_beat_t  o_beat,
    output logic                        o_ovf
);

    localparam int AW = $clog2(`PKT_FIFO_DEPTH);

    pkt_client_pkg::avst_beat_t mem [0:`PKT_FIFO_DEPTH-1];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          do_wr;
    logic          do_rd;

    assign full  = (count == (AW+1)'(`PKT_FIFO_DEPTH));
    assign do_wr = i_wr && !full;
    assign do_rd = i_pop && o_valid;

    assign o_valid = (count != '0);
    assign o_beat  = mem[rd_ptr];

    always_ff @(posedge i_clk_tx) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_beat;
        end
    end

    always_ff @(posedge i_clk_tx) begin
        if (tx_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            o_ovf  <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            // sticky until cleared with the counters
            if (i_ovf_clr) begin
                o_ovf <= 1'b0;
            end else if (i_wr && full) begin
                o_ovf <= 1'b1;
            end
        end
    end

endmodule

//--- hw/pkt_client_csr.sv
/* register bank: configuration registers, control word decode, registered read mux */
`timescale 1ns/1ps
`include "pkt_client_params.svh"

module pkt_client_csr (
    input  logic                        i_clk_tx,
    input  logic                        tx_reset,
    // register bus
    input  logic [`PKT_CSR_ADDR_W-1:0]  i_csr_addr,
    input  logic                        i_csr_read,
    input  logic                        i_csr_write,
    input  logic [31:0]                 i_csr_wdata,
    output logic [31:0]                 o_csr_rdata,
    output logic                        o_csr_rdata_vld,
    // configuration
    output logic                        o_tx_en,
    output logic                        o_cont_mode,
    output logic                        o_loopback_en,
    output logic                        o_cnt_clr,
    output logic [`PKT_ROM_ADDR_W-1:0]  o_rom_start,
    output logic [`PKT_ROM_ADDR_W-1:0]  o_rom_end,
    output logic [`PKT_CNT_W-1:0]       o_loop_cnt,
    // status
    input  logic                        i_gen_done,
    input  logic                        i_fifo_ovf,
    input  pkt_client_pkg::stat_cnt_t   i_tx_stats,
    input  pkt_client_pkg::stat_cnt_t   i_rx_stats
);

    pkt_client_pkg::ctrl_reg_u ctrl_q;
    logic [31:0]               rd_mux;

    // ----------------------------------------------------------------------
    // writes
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk_tx) begin
        if (tx_reset) begin
            ctrl_q.raw  <= '0;
            o_rom_start <= '0;
            o_rom_end   <= '0;
            o_loop_cnt  <= '0;
        end else begin
            // counter clear is a one-cycle pulse
            if (ctrl_q.f.cnt_clr) begin
                ctrl_q.f.cnt_clr <= 1'b0;
            end
            if (i_csr_write) begin
                case (i_csr_addr)
                    `PKT_REG_CTRL:      ctrl_q.raw  <= i_csr_wdata;
                    `PKT_REG_ROM_START: o_rom_start <= i_csr_wdata[`PKT_ROM_ADDR_W-1:0];
                    `PKT_REG_ROM_END:   o_rom_end   <= i_csr_wdata[`PKT_ROM_ADDR_W-1:0];
                    `PKT_REG_LOOP_CNT:  o_loop_cnt  <= i_csr_wdata[`PKT_CNT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // control field decode
    assign o_tx_en       = ctrl_q.f.tx_en;
    assign o_cont_mode   = ctrl_q.f.cont_mode;
    assign o_loopback_en = ctrl_q.f.loopback_en;
    assign o_cnt_clr     = ctrl_q.f.cnt_clr;

    // ----------------------------------------------------------------------
    // reads
    // ----------------------------------------------------------------------
    always_comb begin
        case (i_csr_addr)
            `PKT_REG_CTRL:      rd_mux = ctrl_q.raw;
            `PKT_REG_ROM_START: rd_mux = 32'(o_rom_start);
            `PKT_REG_ROM_END:   rd_mux = 32'(o_rom_end);
            `PKT_REG_LOOP_CNT:  rd_mux = 32'(o_loop_cnt);
            `PKT_REG_STATUS:    rd_mux = {30'd0, i_fifo_ovf, i_gen_done};
            `PKT_REG_TX_SOP:    rd_mux = 32'(i_tx_stats.sop);
            `PKT_REG_TX_EOP:    rd_mux = 32'(i_tx_stats.eop);
            `PKT_REG_TX_ERR:    rd_mux = 32'(i_tx_stats.err);
            `PKT_REG_RX_SOP:    rd_mux = 32'(i_rx_stats.sop);
            `PKT_REG_RX_EOP:    rd_mux = 32'(i_rx_stats.eop);
            `PKT_REG_RX_ERR:    rd_mux = 32'(i_rx_stats.err);
            default:            rd_mux = `PKT_CSR_UNMAPPED;
        endcase
    end

    // read data follows the strobe by one cycle
    always_ff @(posedge i_clk_tx) begin
        if (tx_reset) begin
            o_csr_rdata_vld <= 1'b0;
        end else begin
            o_csr_rdata_vld <= i_csr_read;
        end
    end

    always_ff @(posedge i_clk_tx) begin
        if (i_csr_read) begin
            o_csr_rdata <= rd_mux;
        end
    end

endmodule

//--- hw/pkt_client_params.svh
/* widths, depths and register map of the packet client */
`ifndef PKT_CLIENT_PARAMS_SVH
`define PKT_CLIENT_PARAMS_SVH

// beat format
`define PKT_DATA_W       64
`define PKT_EMPTY_W      3

// storage
`define PKT_ROM_DEPTH    16
`define PKT_ROM_ADDR_W   4
`define PKT_FIFO_DEPTH   16
`define PKT_CNT_W        16

// register bus, word addresses
`define PKT_CSR_ADDR_W   4
`define PKT_REG_CTRL      4'd0
`define PKT_REG_ROM_START 4'd1
`define PKT_REG_ROM_END   4'd2
`define PKT_REG_LOOP_CNT  4'd3
`define PKT_REG_STATUS    4'd4
`define PKT_REG_TX_SOP    4'd5
`define PKT_REG_TX_EOP    4'd6
`define PKT_REG_TX_ERR    4'd7
`define PKT_REG_RX_SOP    4'd8
`define PKT_REG_RX_EOP    4'd9
`define PKT_REG_RX_ERR    4'd10

`define PKT_CSR_UNMAPPED 32'hdeadc0de

`endif

//--- hw/pkt_client_pkg.sv
/* shared types: stream beat, statistics counters, control word */
`include "pkt_client_params.svh"

package pkt_client_pkg;

    // one stream beat, also one ROM word (70 bits)
    typedef struct packed {
        logic                    sop;
        logic                    eop;
        logic [`PKT_EMPTY_W-1:0] empty;
        logic                    error;
        logic [`PKT_DATA_W-1:0]  data;
    } avst_beat_t;

    // per-direction beat counters
    typedef struct packed {
        logic [`PKT_CNT_W-1:0] sop;
        logic [`PKT_CNT_W-1:0] eop;
        logic [`PKT_CNT_W-1:0] err;
    } stat_cnt_t;

    // control register bit fields
    typedef struct packed {
        logic [23:0] rsvd_31_8;
        logic        cnt_clr;
        logic [1:0]  rsvd_6_5;
        logic        loopback_en;
        logic        rsvd_3;
        logic        cont_mode;
        logic        rsvd_1;
        logic        tx_en;
    } ctrl_fields_t;

    // raw bus word or decoded fields
    typedef union packed {
        logic [31:0]  raw;
        ctrl_fields_t f;
    } ctrl_reg_u;

endpackage

//--- hw/pkt_client_top.sv
/* packet client top: register bank, generator, loopback FIFO, tx stage, counters */
`timescale 1ns/1ps
`include "pkt_client_params.svh"

module pkt_client_top (
    input  logic                        i_clk_tx,
    input  logic                        tx_reset,
    // transmit
    input  logic                        i_tx_ready,
    output logic                        o_tx_valid,
    output pkt_client_pkg::avst_beat_t  o_tx_beat,
    // receive
    input  logic                        i_rx_valid,
    input  pkt_client_pkg::avst_beat_t  i_rx_beat,
    // register bus
    input  logic [`PKT_CSR_ADDR_W-1:0]  i_csr_addr,
    input  logic                        i_csr_read,
    input  logic                        i_csr_write,
    input  logic [31:0]                 i_csr_wdata,
    output logic [31:0]                 o_csr_rdata,
    output logic                        o_csr_rdata_vld
);

    logic                       tx_en;
    logic                       cont_mode;
    logic                       loopback_en;
    logic                       cnt_clr;
    logic [`PKT_ROM_ADDR_W-1:0] rom_start;
    logic [`PKT_ROM_ADDR_W-1:0] rom_end;
    logic [`PKT_CNT_W-1:0]      loop_cnt;
    logic                       gen_done;
    logic                       fifo_ovf;
    pkt_client_pkg::stat_cnt_t  tx_stats;
    pkt_client_pkg::stat_cnt_t  rx_stats;

    // source side
    logic                       gen_valid;
    logic                       gen_pop;
    pkt_client_pkg::avst_beat_t gen_beat;
    logic                       fifo_valid;
    logic                       fifo_pop;
    pkt_client_pkg::avst_beat_t fifo_beat;

    // ----------------------------------------------------------------------
    // control
    // ----------------------------------------------------------------------
    pkt_client_csr u_csr (
        .i_clk_tx, .tx_reset,
        .i_csr_addr, .i_csr_read, .i_csr_write, .i_csr_wdata,
        .o_csr_rdata, .o_csr_rdata_vld,
        .o_tx_en(tx_en), .o_cont_mode(cont_mode), .o_loopback_en(loopback_en),
        .o_cnt_clr(cnt_clr), .o_rom_start(rom_start), .o_rom_end(rom_end),
        .o_loop_cnt(loop_cnt),
        .i_gen_done(gen_done), .i_fifo_ovf(fifo_ovf),
        .i_tx_stats(tx_stats), .i_rx_stats(rx_stats)
    );

    // ----------------------------------------------------------------------
    // datapath
    // ----------------------------------------------------------------------
    pkt_gen u_gen (
        .i_clk_tx, .tx_reset,
        .i_tx_en(tx_en), .i_cont_mode(cont_mode),
        .i_rom_start(rom_start), .i_rom_end(rom_end), .i_loop_cnt(loop_cnt),
        .i_pop(gen_pop), .o_valid(gen_valid), .o_beat(gen_beat), .o_done(gen_done)
    );

    lpbk_fifo u_fifo (
        .i_clk_tx, .tx_reset,
        .i_wr(i_rx_valid), .i_wr_beat(i_rx_beat),
        .i_pop(fifo_pop), .i_ovf_clr(cnt_clr),
        .o_valid(fifo_valid), .o_beat(fifo_beat), .o_ovf(fifo_ovf)
    );

    tx_avst_out u_tx_out (
        .i_clk_tx, .tx_reset,
        .i_loopback_en(loopback_en),
        .i_gen_valid(gen_valid), .i_gen_beat(gen_beat),
        .i_fifo_valid(fifo_valid), .i_fifo_beat(fifo_beat),
        .i_tx_ready, .o_gen_pop(gen_pop), .o_fifo_pop(fifo_pop),
        .o_tx_valid, .o_tx_beat
    );

    // counters count accepted tx beats and every rx beat
    pkt_stats u_tx_stats (
        .i_clk_tx, .tx_reset,
        .i_beat_vld(o_tx_valid && i_tx_ready), .i_beat(o_tx_beat),
        .i_clr(cnt_clr), .o_stats(tx_stats)
    );

    pkt_stats u_rx_stats (
        .i_clk_tx, .tx_reset,
        .i_beat_vld(i_rx_valid), .i_beat(i_rx_beat),
        .i_clr(cnt_clr), .o_stats(rx_stats)
    );

endmodule

//--- hw/pkt_gen.sv
/* ROM-driven packet generator with start/end address and loop sequencing */
`timescale 1ns/1ps
`include "pkt_client_params.svh"

module pkt_gen (
    input  logic                        i_clk_tx,
    input  logic                        tx_reset,
    input  logic                        i_tx_en,
    input  logic                        i_cont_mode,
    input  logic [`PKT_ROM_ADDR_W-1:0]  i_rom_start,
    input  logic [`PKT_ROM_ADDR_W-1:0]  i_rom_end,
    input  logic [`PKT_CNT_W-1:0]       i_loop_cnt,
    input  logic                        i_pop,
    output logic                        o_valid,
    output pkt_client_pkg::avst_beat_t  o_beat,
    output logic                        o_done
);

    pkt_client_pkg::avst_beat_t rom [0:`PKT_ROM_DEPTH-1];

    logic [`PKT_ROM_ADDR_W-1:0] addr_q;
    logic [`PKT_CNT_W-1:0]      loops_q;
    logic                       run_q;
    logic                       in_pkt_q;
    logic                       tx_en_q;

    initial begin
        $readmemh("hw/pkt_rom.hex", rom);
    end

    assign o_beat = rom[addr_q];
    // once disabled, only the open packet may still go out
    assign o_valid = run_q && (i_tx_en || in_pkt_q);

    always_ff @(posedge i_clk_tx) begin
        if (tx_reset) begin
            addr_q   <= '0;
            loops_q  <= '0;
            run_q    <= 1'b0;
            in_pkt_q <= 1'b0;
            tx_en_q  <= 1'b0;
            o_done   <= 1'b0;
        end else begin
            tx_en_q <= i_tx_en;
            if (i_tx_en && !tx_en_q) begin
                // enable edge restarts the whole sequence
                run_q    <= 1'b1;
                addr_q   <= i_rom_start;
                loops_q  <= (i_loop_cnt == '0) ? `PKT_CNT_W'(1) : i_loop_cnt;
                in_pkt_q <= 1'b0;
                o_done   <= 1'b0;
            end else if (i_pop) begin
                in_pkt_q <= !o_beat.eop;
                if (addr_q == i_rom_end) begin
                    addr_q <= i_rom_start;
                    if (!i_cont_mode) begin
                        if (loops_q <= `PKT_CNT_W'(1)) begin
                            run_q  <= 1'b0;
                            o_done <= 1'b1;
                        end else begin
                            loops_q <= loops_q - 1'b1;
                        end
                    end
                end else begin
                    addr_q <= addr_q + 1'b1;
                end
            end else if (!i_tx_en && !in_pkt_q) begin
                // disabled at a packet boundary
                run_q <= 1'b0;
            end
        end
    end

endmodule

//--- hw/pkt_rom.hex
// top byte: sop eop empty[2:0] error in bits 5..0
// low 16 digits: beat data
205a5a000000000000
005a5a000000000001
005a5a000000000002
105a5a000000000003
205a5a000000000004
005a5a000000000005
005a5a000000000006
155a5a000000000007
205a5a000000000008
005a5a000000000009
005a5a00000000000a
1a5a5a00000000000b
205a5a00000000000c
005a5a00000000000d
005a5a00000000000e
105a5a00000000000f

//--- hw/pkt_stats.sv
/* saturating sop, eop and error beat counters for one direction */
`timescale 1ns/1ps
`include "pkt_client_params.svh"

module pkt_stats (
    input  logic                        i_clk_tx,
    input  logic                        tx_reset,
    input  logic                        i_beat_vld,
    input  pkt_client_pkg::avst_beat_t  i_beat,
    input  logic                        i_clr,
    output pkt_client_pkg::stat_cnt_t   o_stats
);

    function automatic logic [`PKT_CNT_W-1:0] sat_inc(input logic [`PKT_CNT_W-1:0] v,
                                                       input logic hit);
        return (hit && v != '1) ? v + 1'b1 : v;
    endfunction

    always_ff @(posedge i_clk_tx) begin
        if (tx_reset || i_clr) begin
            o_stats <= '0;
        end else if (i_beat_vld) begin
            o_stats.sop <= sat_inc(o_stats.sop, i_beat.sop);
            o_stats.eop <= sat_inc(o_stats.eop, i_beat.eop);
            o_stats.err <= sat_inc(o_stats.err, i_beat.error);
        end
    end

endmodule

//--- hw/tx_avst_out.sv
/* source select between generator and loopback, registered tx output stage */
`timescale 1ns/1ps
`include "pkt_client_params.svh"

module tx_avst_out (
    input  logic                        i_clk_tx,
    input  logic                        tx_reset,
    input  logic                        i_loopback_en,
    input  logic                        i_gen_valid,
    input  pkt_client_pkg::avst_beat_t  i_gen_beat,
    input  logic                        i_fifo_valid,
    input  pkt_client_pkg::avst_beat_t  i_fifo_beat,
    input  logic                        i_tx_ready,
    output logic                        o_gen_pop,
    output logic                        o_fifo_pop,
    output logic                        o_tx_valid,
    output pkt_client_pkg::avst_beat_t  o_tx_beat
);

    pkt_client_pkg::avst_beat_t src_beat;
    logic                       sel_lpbk_q;
    logic                       sel_lpbk;
    logic                       pkt_open_q;
    logic                       src_valid;
    logic                       load;

    // select may only follow the control bit between packets
    assign sel_lpbk  = pkt_open_q ? sel_lpbk_q : i_loopback_en;
    assign src_valid = sel_lpbk ? i_fifo_valid : i_gen_valid;
    assign src_beat  = sel_lpbk ? i_fifo_beat : i_gen_beat;

    // load when empty or when the held beat leaves this cycle
    assign load       = src_valid && (!o_tx_valid || i_tx_ready);
    assign o_gen_pop  = load && !sel_lpbk;
    assign o_fifo_pop = load && sel_lpbk;

    always_ff @(posedge i_clk_tx) begin
        if (tx_reset) begin
            o_tx_valid <= 1'b0;
            pkt_open_q <= 1'b0;
            sel_lpbk_q <= 1'b0;
        end else begin
            sel_lpbk_q <= sel_lpbk;
            if (load) begin
                o_tx_valid <= 1'b1;
                pkt_open_q <= !src_beat.eop;
            end else if (i_tx_ready) begin
                o_tx_valid <= 1'b0;
            end
        end
    end

    // beat holds while the MAC is not ready
    always_ff @(posedge i_clk_tx) begin
        if (load) begin
            o_tx_beat <= src_beat;
        end
    end

endmodule

//--- list.f
+incdir+hw
hw/pkt_client_pkg.sv
hw/pkt_client_csr.sv
hw/pkt_gen.sv
hw/lpbk_fifo.sv
hw/tx_avst_out.sv
hw/pkt_stats.sv
hw/pkt_client_top.sv
sim/pkt_client_properties.sv
sim/tb_pkt_client.sv

//--- sim/pkt_client_properties.sv
/* concurrent checks on the tx output stage and the register read strobe */
`timescale 1ns/1ps

module pkt_client_properties (
    input logic                        i_clk_tx,
    input logic                        tx_reset,
    input logic                        i_tx_ready,
    input logic                        o_tx_valid,
    input pkt_client_pkg::avst_beat_t  o_tx_beat,
    input logic                        i_csr_read,
    input logic                        o_csr_rdata_vld
);

    // output register empty right after reset
    a_valid_after_reset: assert property (@(posedge i_clk_tx) tx_reset |=> !o_tx_valid)
        else $error("tx valid high in the cycle after reset");

    // beat held while the MAC stalls
    a_beat_stable: assert property (@(posedge i_clk_tx) disable iff (tx_reset)
        (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_beat)))
        else $error("tx beat changed under back-pressure");

    a_rdata_vld: assert property (@(posedge i_clk_tx) disable iff (tx_reset)
        o_csr_rdata_vld |-> $past(i_csr_read))
        else $error("read data valid without a read strobe");

endmodule

bind tx_avst_out pkt_client_properties tx_props_i (
    .i_clk_tx(i_clk_tx), .tx_reset(tx_reset), .i_tx_ready(i_tx_ready),
    .o_tx_valid(o_tx_valid), .o_tx_beat(o_tx_beat),
    .i_csr_read(1'b0), .o_csr_rdata_vld(1'b0)
);

bind pkt_client_csr pkt_client_properties csr_props_i (
    .i_clk_tx(i_clk_tx), .tx_reset(tx_reset), .i_tx_ready(1'b1),
    .o_tx_valid(1'b0), .o_tx_beat('0),
    .i_csr_read(i_csr_read), .o_csr_rdata_vld(o_csr_rdata_vld)
);

//--- sim/tb_pkt_client.sv
/* packet client testbench: table of register, generator, loopback and overflow tests */
`timescale 1ns/1ps
`include "pkt_client_params.svh"

module tb_pkt_client;

    // kind 0 regs, 1 generator, 2 tx counters, 3 loopback, 4 overflow
    // ready_mode 0 always ready, 1 random, 2 held low
    typedef struct packed {
        logic [2:0]  kind;
        logic [7:0]  ctrl;
        logic [3:0]  rom_start;
        logic [3:0]  rom_end;
        logic [7:0]  loops;
        logic [7:0]  rx_beats;
        logic [1:0]  ready_mode;
        logic [7:0]  tx_beats;
    } test_t;

    test_t tbl [0:4] = '{
        '{3'd0, 8'h00, 4'd4, 4'd7, 8'd2, 8'd0,  2'd0, 8'd0},
        '{3'd1, 8'h01, 4'd4, 4'd7, 8'd2, 8'd0,  2'd1, 8'd8},
        '{3'd2, 8'h00, 4'd4, 4'd7, 8'd2, 8'd0,  2'd0, 8'd0},
        '{3'd3, 8'h10, 4'd0, 4'd0, 8'd0, 8'd12, 2'd0, 8'd12},
        '{3'd4, 8'h10, 4'd0, 4'd0, 8'd0, 8'd20, 2'd2, 8'd0}
    };
    string tbl_name [0:4] = '{"regs", "gen_replay", "tx_counts", "loopback", "overflow"};

    logic                       i_clk_tx;
    logic                       tx_reset;
    logic                       i_tx_ready;
    logic                       o_tx_valid;
    pkt_client_pkg::avst_beat_t o_tx_beat;
    logic                       i_rx_valid;
    pkt_client_pkg::avst_beat_t i_rx_beat;
    logic [3:0]                 i_csr_addr;
    logic                       i_csr_read;
    logic                       i_csr_write;
    logic [31:0]                i_csr_wdata;
    logic [31:0]                o_csr_rdata;
    logic                       o_csr_rdata_vld;

    pkt_client_pkg::avst_beat_t tx_q [$];
    pkt_client_pkg::avst_beat_t rx_q [$];
    pkt_client_pkg::avst_beat_t gen_q [$];
    logic [69:0]                rom_img [0:15];
    logic [15:0]                lfsr_q = 16'd90;
    logic [1:0]                 ready_mode = 2'd0;
    string                      cur_name;
    int                         errors = 0;
    int                         test_errs = 0;
    int                         checks = 0;
    int                         fails = 0;
    int                         cycles = 0;
    int                         limit = 0;

    pkt_client_top pkt_client_top_i (.*);

    initial begin
        i_clk_tx = 1'b0;
        forever #5 i_clk_tx = ~i_clk_tx;
    end

    // taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic check(input string what, input logic [69:0] exp, input logic [69:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            test_errs++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
        end
    endtask

    task automatic csr_write(input logic [3:0] a, input logic [31:0] d);
        @(posedge i_clk_tx);
        i_csr_addr  <= a;
        i_csr_wdata <= d;
        i_csr_write <= 1'b1;
        @(posedge i_clk_tx);
        i_csr_write <= 1'b0;
    endtask

    task automatic read_check(input string what, input logic [3:0] a,
                              input logic [31:0] mask, input logic [31:0] exp);
        @(posedge i_clk_tx);
        i_csr_addr <= a;
        i_csr_read <= 1'b1;
        @(posedge i_clk_tx);
        i_csr_read <= 1'b0;
        @(negedge i_clk_tx);
        while (!o_csr_rdata_vld) @(negedge i_clk_tx);
        check(what, exp & mask, o_csr_rdata & mask);
    endtask

    // packets of four beats with random data, empty and error on the last
    task automatic drive_rx(input int n);
        pkt_client_pkg::avst_beat_t b;
        for (int i = 0; i < n; i++) begin
            b.sop   = (i % 4 == 0);
            b.eop   = (i % 4 == 3);
            b.error = b.eop ? rand_bits(1) : 1'b0;
            b.empty = b.eop ? rand_bits(3) : 3'd0;
            b.data  = rand_bits(64);
            @(posedge i_clk_tx);
            i_rx_valid <= 1'b1;
            i_rx_beat  <= b;
            rx_q.push_back(b);
        end
        @(posedge i_clk_tx);
        i_rx_valid <= 1'b0;
    endtask

    task automatic wait_tx(input int n);
        while (tx_q.size() < n) @(posedge i_clk_tx);
    endtask

    task automatic count_flags(input pkt_client_pkg::avst_beat_t q [$],
                               output int s, output int e, output int r);
        s = 0;
        e = 0;
        r = 0;
        foreach (q[i]) begin
            s += q[i].sop;
            e += q[i].eop;
            r += q[i].error;
        end
    endtask

    // ------------------------------------------------------------------
    // MAC side: ready pattern and capture of transferred beats
    // ------------------------------------------------------------------
    always @(posedge i_clk_tx) begin
        case (ready_mode)
            2'd1:    i_tx_ready <= rand_bits(1) != 0;
            2'd2:    i_tx_ready <= 1'b0;
            default: i_tx_ready <= 1'b1;
        endcase
    end

    always @(negedge i_clk_tx) begin
        if (!tx_reset && o_tx_valid && i_tx_ready) begin
            tx_q.push_back(o_tx_beat);
        end
    end

    always @(posedge i_clk_tx) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Errors found");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        int ns;
        int ne;
        int nr;
        int idx;
        tx_reset    = 1'b1;
        i_tx_ready  = 1'b0;
        i_rx_valid  = 1'b0;
        i_rx_beat   = '0;
        i_csr_addr  = '0;
        i_csr_read  = 1'b0;
        i_csr_write = 1'b0;
        i_csr_wdata = '0;
        $readmemh("hw/pkt_rom.hex", rom_img);
        limit = 200;
        foreach (tbl[t]) limit += (tbl[t].tx_beats + tbl[t].rx_beats) * 4;
        repeat (4) @(posedge i_clk_tx);
        tx_reset <= 1'b0;

        foreach (tbl[t]) begin
            cur_name   = tbl_name[t];
            test_errs  = 0;
            ready_mode = tbl[t].ready_mode;
            tx_q.delete();
            rx_q.delete();
            case (tbl[t].kind)
                3'd0: begin
                    csr_write(`PKT_REG_ROM_START, 32'(tbl[t].rom_start));
                    csr_write(`PKT_REG_ROM_END, 32'(tbl[t].rom_end));
                    csr_write(`PKT_REG_LOOP_CNT, 32'(tbl[t].loops));
                    read_check("start", `PKT_REG_ROM_START, '1, 32'(tbl[t].rom_start));
                    read_check("end", `PKT_REG_ROM_END, '1, 32'(tbl[t].rom_end));
                    read_check("loops", `PKT_REG_LOOP_CNT, '1, 32'(tbl[t].loops));
                    read_check("unmapped", 4'hf, '1, `PKT_CSR_UNMAPPED);
                end
                3'd1: begin
                    gen_q.delete();
                    csr_write(`PKT_REG_CTRL, 32'(tbl[t].ctrl));
                    wait_tx(tbl[t].tx_beats);
                    for (int i = 0; i < tbl[t].tx_beats; i++) begin
                        idx = tbl[t].rom_start + i % (tbl[t].rom_end - tbl[t].rom_start + 1);
                        gen_q.push_back(rom_img[idx]);
                        check($sformatf("beat %0d", i), rom_img[idx], tx_q[i]);
                    end
                    read_check("gen_done", `PKT_REG_STATUS, 32'h1, 32'h1);
                    csr_write(`PKT_REG_CTRL, 32'h0);
                    repeat (8) @(negedge i_clk_tx);
                    check("beat count", 70'(tbl[t].tx_beats), 70'(tx_q.size()));
                end
                3'd2: begin
                    count_flags(gen_q, ns, ne, nr);
                    read_check("tx sop", `PKT_REG_TX_SOP, '1, ns);
                    read_check("tx eop", `PKT_REG_TX_EOP, '1, ne);
                    read_check("tx err", `PKT_REG_TX_ERR, '1, nr);
                end
                3'd3: begin
                    csr_write(`PKT_REG_CTRL, 32'(tbl[t].ctrl));
                    drive_rx(tbl[t].rx_beats);
                    wait_tx(tbl[t].tx_beats);
                    for (int i = 0; i < tbl[t].tx_beats; i++) begin
                        check($sformatf("beat %0d", i), rx_q[i], tx_q[i]);
                    end
                    count_flags(rx_q, ns, ne, nr);
                    read_check("rx sop", `PKT_REG_RX_SOP, '1, ns);
                    read_check("rx eop", `PKT_REG_RX_EOP, '1, ne);
                    read_check("rx err", `PKT_REG_RX_ERR, '1, nr);
                end
                default: begin
                    repeat (2) @(posedge i_clk_tx);
                    drive_rx(tbl[t].rx_beats);
                    read_check("fifo_ovf set", `PKT_REG_STATUS, 32'h2, 32'h2);
                    csr_write(`PKT_REG_CTRL, 32'(tbl[t].ctrl) | 32'h80);
                    for (int a = `PKT_REG_TX_SOP; a <= `PKT_REG_RX_ERR; a++) begin
                        read_check($sformatf("counter %0d", a), 4'(a), '1, 32'h0);
                    end
                    read_check("fifo_ovf clear", `PKT_REG_STATUS, 32'h2, 32'h0);
                end
            endcase
            if (test_errs != 0) fails++;
            $display("test %-10s %s, %0d mismatches", cur_name,
                     (test_errs == 0) ? "passed" : "FAILED", test_errs);
        end

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                 $size(tbl), fails, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
